// ==== common/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and instruction word
`define WORD_W 16

// 512-word unified memory
`define ADDR_W 9
`define MEM_DEPTH 512

// register file
`define REG_IDX_W 3
`define NUM_REGS 8

`endif

// ==== common/isa_pkg.sv ====
package isa_pkg;

	// major operation, instr[15:13]
	typedef enum logic [2:0]
	{
		OPC_LDR  = 3'b011,
		OPC_STR  = 3'b100,
		OPC_ALU  = 3'b101,
		OPC_MOV  = 3'b110,
		OPC_HALT = 3'b111
	} opcode_t;

	typedef enum logic [1:0]
	{
		ALU_ADD = 2'b00,
		ALU_CMP = 2'b01, // subtract, flags only
		ALU_AND = 2'b10,
		ALU_MVN = 2'b11
	} alu_op_t;

	// MOV reuses the op field, 10 selects the imm8 form
	localparam alu_op_t MOV_IMM_FORM = alu_op_t'(2'b10);

	typedef enum logic [1:0]
	{
		SH_NONE = 2'b00,
		SH_LSL  = 2'b01,
		SH_LSR  = 2'b10,
		SH_ASR  = 2'b11
	} shift_t;

	localparam int OPC_HI = 15;
	localparam int OPC_LO = 13;
	localparam int OP_HI = 12;
	localparam int OP_LO = 11;
	localparam int RN_LO = 8;
	localparam int RD_LO = 5;
	localparam int SH_HI = 4;
	localparam int SH_LO = 3;
	localparam int RM_LO = 0;
	localparam int IMM8_W = 8;
	localparam int IMM5_W = 5;

endpackage

// ==== common/ctrl_pkg.sv ====
package ctrl_pkg;

	typedef enum logic [3:0]
	{
		ST_RESET,
		ST_FETCH1,
		ST_FETCH2,
		ST_UPDATE,
		ST_DECODE,
		ST_A,
		ST_B,
		ST_C,
		ST_D,
		ST_E,
		ST_F,
		ST_G,
		ST_H,
		ST_HALT
	} ctrl_state_t;

	typedef enum logic [1:0]
	{
		MEM_NONE  = 2'b00,
		MEM_READ  = 2'b01,
		MEM_WRITE = 2'b11
	} mem_cmd_t;

	// register file write source
	typedef enum logic [1:0]
	{
		WB_C     = 2'b00,
		WB_IMM8  = 2'b01,
		WB_MDATA = 2'b10
	} wb_sel_t;

	typedef enum logic [1:0]
	{
		SEL_RN = 2'b00,
		SEL_RD = 2'b01,
		SEL_RM = 2'b10
	} reg_sel_t;

endpackage

// ==== datapath/alu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu
	import isa_pkg::*;
(
	input  logic [`WORD_W-1:0] a,
	input  logic [`WORD_W-1:0] b,
	input  alu_op_t            op,
	output logic [`WORD_W-1:0] result,
	output logic               n,
	output logic               v,
	output logic               z
);

	localparam int MSB = `WORD_W - 1;

	always_comb
	begin
		v = 1'b0;
		case (op)
			ALU_ADD: result = a + b;
			ALU_CMP:
			begin
				result = a - b;
				v = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]); // signed overflow
			end
			ALU_AND: result = a & b;
			default: result = ~b;
		endcase
	end

	assign n = result[MSB];
	assign z = (result == '0);

endmodule

// ==== datapath/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath
	import isa_pkg::*, ctrl_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`REG_IDX_W-1:0] reg_num,
	input  logic                  write,
	input  wb_sel_t               wb_sel,
	input  logic                  load_a,
	input  logic                  load_b,
	input  logic                  load_c,
	input  logic                  load_status,
	input  logic                  a_sel,
	input  logic                  b_sel,
	input  shift_t                shift,
	input  alu_op_t               op,
	input  logic [`WORD_W-1:0]    mdata,
	input  logic [`WORD_W-1:0]    sximm8,
	input  logic [`WORD_W-1:0]    sximm5,
	output logic [`WORD_W-1:0]    c_out,
	output logic                  n,
	output logic                  v,
	output logic                  z
);

	logic [`WORD_W-1:0] regs [`NUM_REGS];
	logic [`WORD_W-1:0] wb_data;
	logic [`WORD_W-1:0] a_reg, b_reg;
	logic [`WORD_W-1:0] b_shifted;
	logic [`WORD_W-1:0] a_in, b_in;
	logic [`WORD_W-1:0] alu_out;
	logic alu_n, alu_v, alu_z;

	always_comb
	begin
		case (wb_sel)
			WB_IMM8:  wb_data = sximm8;
			WB_MDATA: wb_data = mdata;
			default:  wb_data = c_out;
		endcase
	end

	// one index serves both read and write, the FSM never needs two at once
	always_ff @(posedge clk)
	begin
		if (write)
			regs[reg_num] <= wb_data;
		if (load_a)
			a_reg <= regs[reg_num];
		if (load_b)
			b_reg <= regs[reg_num];
		if (load_c)
			c_out <= alu_out;
	end

	always_comb
	begin
		case (shift)
			SH_LSL:  b_shifted = {b_reg[`WORD_W-2:0], 1'b0};
			SH_LSR:  b_shifted = {1'b0, b_reg[`WORD_W-1:1]};
			SH_ASR:  b_shifted = {b_reg[`WORD_W-1], b_reg[`WORD_W-1:1]};
			default: b_shifted = b_reg;
		endcase
	end

	assign a_in = a_sel ? '0 : a_reg;
	assign b_in = b_sel ? sximm5 : b_shifted;

	alu i_alu (
		.a(a_in), .b(b_in), .op(op),
		.result(alu_out), .n(alu_n), .v(alu_v), .z(alu_z)
	);

	// status only changes on CMP
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			n <= 1'b0;
			v <= 1'b0;
			z <= 1'b0;
		end
		else if (load_status)
		begin
			n <= alu_n;
			v <= alu_v;
			z <= alu_z;
		end
	end

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module instr_decode
	import isa_pkg::*;
(
	input  logic [`WORD_W-1:0]    instr,
	output opcode_t               opcode,
	output alu_op_t               op,
	output logic [`REG_IDX_W-1:0] rn,
	output logic [`REG_IDX_W-1:0] rd,
	output logic [`REG_IDX_W-1:0] rm,
	output shift_t                shift,
	output logic [`WORD_W-1:0]    sximm8,
	output logic [`WORD_W-1:0]    sximm5
);

	logic mem_op;

	assign opcode = opcode_t'(instr[OPC_HI:OPC_LO]);
	assign op = alu_op_t'(instr[OP_HI:OP_LO]);

	assign rn = instr[RN_LO +: `REG_IDX_W];
	assign rd = instr[RD_LO +: `REG_IDX_W];
	assign rm = instr[RM_LO +: `REG_IDX_W];

	// LDR/STR carry imm5 where the shift field would be
	assign mem_op = (opcode == OPC_LDR) || (opcode == OPC_STR);
	assign shift = mem_op ? SH_NONE : shift_t'(instr[SH_HI:SH_LO]);

	assign sximm8 = {{(`WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
	assign sximm5 = {{(`WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};

endmodule

// ==== controller/cpu_fsm.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_fsm
	import isa_pkg::*, ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  opcode_t  opcode,
	input  alu_op_t  op,
	output reg_sel_t reg_sel,
	output wb_sel_t  wb_sel,
	output logic     write,
	output alu_op_t  alu_op,
	output logic     load_a,
	output logic     load_b,
	output logic     load_c,
	output logic     load_status,
	output logic     a_sel,
	output logic     b_sel,
	output mem_cmd_t mem_cmd,
	output logic     addr_sel,
	output logic     load_ir,
	output logic     load_pc,
	output logic     reset_pc,
	output logic     load_addr,
	output logic     halted
);

	ctrl_state_t state, next_state;
	logic mov_imm;
	logic is_cmp;

	assign mov_imm = (op == MOV_IMM_FORM);
	assign is_cmp = (op == ALU_CMP);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_RESET;
		else
			state <= next_state;
	end

	// step count per group: MOV imm 1, MOV reg 3, ALU 4, LDR 6, STR 8
	always_comb
	begin
		next_state = ST_FETCH1;
		case (state)
			ST_FETCH1: next_state = ST_FETCH2;
			ST_FETCH2: next_state = ST_UPDATE;
			ST_UPDATE: next_state = ST_DECODE;
			ST_DECODE:
			begin
				case (opcode)
					OPC_MOV, OPC_ALU, OPC_LDR, OPC_STR: next_state = ST_A;
					OPC_HALT: next_state = ST_HALT;
					default: next_state = ST_FETCH1; // undefined opcode is skipped
				endcase
			end
			ST_A: next_state = (opcode == OPC_MOV && mov_imm) ? ST_FETCH1 : ST_B;
			ST_B: next_state = ST_C;
			ST_C: next_state = (opcode == OPC_MOV) ? ST_FETCH1 : ST_D;
			ST_D: next_state = (opcode == OPC_ALU) ? ST_FETCH1 : ST_E;
			ST_E: next_state = ST_F;
			ST_F: next_state = (opcode == OPC_LDR) ? ST_FETCH1 : ST_G;
			ST_G: next_state = ST_H;
			ST_HALT: next_state = ST_HALT; // held until reset
			default: next_state = ST_FETCH1;
		endcase
	end

	always_comb
	begin
		reg_sel = SEL_RN;
		wb_sel = WB_C;
		write = 1'b0;
		alu_op = ALU_ADD;
		load_a = 1'b0;
		load_b = 1'b0;
		load_c = 1'b0;
		load_status = 1'b0;
		a_sel = 1'b0;
		b_sel = 1'b0;
		mem_cmd = MEM_NONE;
		addr_sel = 1'b1;
		load_ir = 1'b0;
		load_pc = 1'b0;
		reset_pc = 1'b0;
		load_addr = 1'b0;
		halted = 1'b0;

		case (state)
			ST_RESET:
			begin
				load_pc = 1'b1;
				reset_pc = 1'b1;
			end
			ST_FETCH1: mem_cmd = MEM_READ;
			ST_FETCH2:
			begin
				mem_cmd = MEM_READ;
				load_ir = 1'b1;
			end
			ST_UPDATE: load_pc = 1'b1;
			ST_A:
			begin
				if (opcode == OPC_MOV && mov_imm)
				begin
					wb_sel = WB_IMM8; // Rn = sximm8
					write = 1'b1;
				end
				else if (opcode == OPC_MOV)
				begin
					reg_sel = SEL_RM;
					load_b = 1'b1;
				end
				else
					load_a = 1'b1; // base or first operand from Rn
			end
			ST_B:
			begin
				if (opcode == OPC_ALU)
				begin
					reg_sel = SEL_RM;
					load_b = 1'b1;
				end
				else
				begin
					a_sel = (opcode == OPC_MOV); // 0 + shifted B
					b_sel = (opcode != OPC_MOV); // Rn + sximm5
					load_c = 1'b1;
				end
			end
			ST_C:
			begin
				if (opcode == OPC_MOV)
				begin
					reg_sel = SEL_RD;
					write = 1'b1;
				end
				else if (opcode == OPC_ALU)
				begin
					alu_op = op;
					load_status = is_cmp;
					load_c = !is_cmp;
				end
				else
					load_addr = 1'b1;
			end
			ST_D:
			begin
				if (opcode == OPC_ALU)
				begin
					reg_sel = SEL_RD;
					write = !is_cmp;
				end
				else
					addr_sel = 1'b0; // point memory at the data address
			end
			ST_E:
			begin
				addr_sel = 1'b0;
				if (opcode == OPC_LDR)
					mem_cmd = MEM_READ;
				else
				begin
					reg_sel = SEL_RD;
					load_b = 1'b1; // store data
				end
			end
			ST_F:
			begin
				addr_sel = 1'b0;
				if (opcode == OPC_LDR)
				begin
					mem_cmd = MEM_READ; // keep read_data valid for the write
					reg_sel = SEL_RD;
					wb_sel = WB_MDATA;
					write = 1'b1;
				end
				else
				begin
					a_sel = 1'b1;
					load_c = 1'b1;
				end
			end
			ST_G:
			begin
				addr_sel = 1'b0;
				mem_cmd = MEM_WRITE;
			end
			ST_H: addr_sel = 1'b0;
			ST_HALT: halted = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== hdl/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu
	import isa_pkg::*, ctrl_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic [`WORD_W-1:0]  read_data,
	output logic [`WORD_W-1:0]  out,
	output logic                n,
	output logic                v,
	output logic                z,
	output logic                halted,
	output mem_cmd_t            mem_cmd,
	output logic [`ADDR_W-1:0]  mem_addr
);

	logic [`WORD_W-1:0] ir;
	logic [`ADDR_W-1:0] pc;
	logic [`ADDR_W-1:0] next_pc;
	logic [`ADDR_W-1:0] data_addr;

	opcode_t opcode;
	alu_op_t op;
	alu_op_t alu_op;
	shift_t shift;
	logic [`REG_IDX_W-1:0] rn, rd, rm;
	logic [`REG_IDX_W-1:0] reg_num;
	logic [`WORD_W-1:0] sximm8, sximm5;
	logic [`WORD_W-1:0] c_out;

	reg_sel_t reg_sel;
	wb_sel_t wb_sel;
	logic write, load_a, load_b, load_c, load_status;
	logic a_sel, b_sel;
	logic addr_sel, load_ir, load_pc, reset_pc, load_addr;

	always_ff @(posedge clk)
	begin
		if (load_ir)
			ir <= read_data;
	end

	assign next_pc = reset_pc ? '0 : pc + 1'b1;

	always_ff @(posedge clk)
	begin
		if (load_pc)
			pc <= next_pc;
	end

	// LDR/STR address from the low bits of C
	always_ff @(posedge clk)
	begin
		if (load_addr)
			data_addr <= c_out[`ADDR_W-1:0];
	end

	assign mem_addr = addr_sel ? pc : data_addr;
	assign out = c_out; // store data

	always_comb
	begin
		case (reg_sel)
			SEL_RD:  reg_num = rd;
			SEL_RM:  reg_num = rm;
			default: reg_num = rn;
		endcase
	end

	instr_decode i_decode (
		.instr(ir), .opcode(opcode), .op(op), .rn(rn), .rd(rd), .rm(rm),
		.shift(shift), .sximm8(sximm8), .sximm5(sximm5)
	);

	cpu_fsm i_fsm (
		.clk(clk), .reset(reset), .opcode(opcode), .op(op),
		.reg_sel(reg_sel), .wb_sel(wb_sel), .write(write), .alu_op(alu_op),
		.load_a(load_a), .load_b(load_b), .load_c(load_c), .load_status(load_status),
		.a_sel(a_sel), .b_sel(b_sel), .mem_cmd(mem_cmd), .addr_sel(addr_sel),
		.load_ir(load_ir), .load_pc(load_pc), .reset_pc(reset_pc),
		.load_addr(load_addr), .halted(halted)
	);

	datapath i_datapath (
		.clk(clk), .reset(reset), .reg_num(reg_num), .write(write), .wb_sel(wb_sel),
		.load_a(load_a), .load_b(load_b), .load_c(load_c), .load_status(load_status),
		.a_sel(a_sel), .b_sel(b_sel), .shift(shift), .op(alu_op),
		.mdata(read_data), .sximm8(sximm8), .sximm5(sximm5),
		.c_out(c_out), .n(n), .v(v), .z(z)
	);

endmodule

// ==== testbench/tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// image written to memory before each run, and the model's final memory
logic [`WORD_W-1:0] image [`MEM_DEPTH];
logic [`WORD_W-1:0] model_mem [`MEM_DEPTH];
int plen;

function automatic void append_word(input logic [`WORD_W-1:0] w);
	image[plen] = w;
	plen++;
endfunction

function automatic logic [`WORD_W-1:0] mov_imm_word(input int rn, int imm8);
	return {OPC_MOV, MOV_IMM_FORM, rn[2:0], imm8[7:0]};
endfunction

function automatic logic [`WORD_W-1:0] mov_reg_word(input int rd, int rm, int sh);
	return {OPC_MOV, ALU_ADD, 3'd0, rd[2:0], sh[1:0], rm[2:0]};
endfunction

function automatic logic [`WORD_W-1:0] alu_word(input alu_op_t op, int rn, int rd, int rm,
	int sh);
	return {OPC_ALU, op, rn[2:0], rd[2:0], sh[1:0], rm[2:0]};
endfunction

// LDR and STR share one layout, imm5 in the low bits
function automatic logic [`WORD_W-1:0] ldr_str_word(input opcode_t opc, int rd, int rn,
	int imm5);
	return {opc, 2'b00, rn[2:0], rd[2:0], imm5[4:0]};
endfunction

function automatic logic [`WORD_W-1:0] halt_word();
	return {OPC_HALT, 13'd0};
endfunction

function automatic logic [`WORD_W-1:0] shift_value(input logic [`WORD_W-1:0] x,
	input logic [1:0] sh);
	case (sh)
		SH_LSL: return x << 1;
		SH_LSR: return x >> 1;
		SH_ASR: return $signed(x) >>> 1;
		default: return x;
	endcase
endfunction

// executes the image one instruction at a time, status as {n, v, z}
function automatic void run_model(output logic done, output logic [2:0] nvz);
	logic [`WORD_W-1:0] r [`NUM_REGS];
	logic [`WORD_W-1:0] ins;
	logic [`WORD_W-1:0] b;
	logic [`WORD_W-1:0] sum;
	logic [`WORD_W:0] diff;
	logic [`ADDR_W-1:0] pc;
	logic [`ADDR_W-1:0] addr;
	logic [2:0] rn;
	logic [2:0] rd;
	done = 1'b0;
	nvz = 3'b000; // status after reset
	pc = '0;
	model_mem = image;
	for (int i = 0; i < `MEM_DEPTH && !done; i++)
	begin
		ins = model_mem[pc];
		pc = pc + 1'b1;
		rn = ins[10:8];
		rd = ins[7:5];
		b = shift_value(r[ins[2:0]], ins[4:3]);
		sum = r[rn] + {{(`WORD_W-5){ins[4]}}, ins[4:0]};
		addr = sum[`ADDR_W-1:0];
		case (ins[15:13])
			OPC_MOV:
			begin
				if (ins[12:11] == MOV_IMM_FORM)
					r[rn] = {{(`WORD_W-8){ins[7]}}, ins[7:0]};
				else
					r[rd] = b;
			end
			OPC_ALU:
			begin
				case (ins[12:11])
					ALU_ADD: r[rd] = r[rn] + b;
					ALU_AND: r[rd] = r[rn] & b;
					ALU_MVN: r[rd] = ~b;
					default:
					begin
						diff = {r[rn][`WORD_W-1], r[rn]} - {b[`WORD_W-1], b};
						// overflow when the extra sign bit disagrees
						nvz = {diff[`WORD_W-1], diff[`WORD_W] != diff[`WORD_W-1],
							diff[`WORD_W-1:0] == '0};
					end
				endcase
			end
			OPC_LDR: r[rd] = model_mem[addr];
			OPC_STR: model_mem[addr] = r[rd];
			OPC_HALT: done = 1'b1;
			default: ;
		endcase
	end
endfunction

`endif

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu
	import isa_pkg::*, ctrl_pkg::*;
();

	localparam int WORST_CYCLES = 12; // fetch, update, decode and 8 STR steps
	localparam int RUN_MARGIN = 40;   // reset, image load and the watch after halt
	localparam int DATA_BASE = 96;

	logic clk;
	logic reset;
	logic load_image;
	logic [`WORD_W-1:0] read_data;
	logic [`WORD_W-1:0] out;
	logic n, v, z, halted;
	mem_cmd_t mem_cmd;
	logic [`ADDR_W-1:0] mem_addr;
	logic [`WORD_W-1:0] mem [`MEM_DEPTH];
	logic [`WORD_W-1:0] rnd;
	int cycles = 0;
	int cycle_limit = 0;

	`include "tb_isa_model.svh"

	cpu i_dut (
		.clk(clk), .reset(reset), .read_data(read_data), .out(out),
		.n(n), .v(v), .z(z), .halted(halted), .mem_cmd(mem_cmd), .mem_addr(mem_addr)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign read_data = (mem_cmd == MEM_READ) ? mem[mem_addr] : '0;

	always @(posedge clk)
	begin
		if (load_image)
			mem <= image; // whole image in one edge
		else if (mem_cmd == MEM_WRITE)
			mem[mem_addr] <= out;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the CPU did not reach HALT within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input logic [`WORD_W-1:0] expected,
		input logic [`WORD_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	// every word tagged with its own address, random data around DATA_BASE
	task automatic fresh_image();
		for (int i = 0; i < `MEM_DEPTH; i++)
			image[i] = {7'h55, i[`ADDR_W-1:0]};
		for (int i = DATA_BASE - 16; i < DATA_BASE + 16; i++)
			image[i] = 16'($urandom());
		plen = 0;
	endtask

	task automatic run_program(input string name);
		logic model_done;
		logic [2:0] model_nvz;
		append_word(halt_word());
		cycle_limit += plen * WORST_CYCLES + RUN_MARGIN;
		run_model(model_done, model_nvz);
		if (!model_done)
		begin
			$display("the reference model never reached HALT in %s", name);
			$display("** FAIL **");
			$fatal(1, "model ran off the program");
		end
		@(negedge clk);
		reset = 1'b1;
		load_image = 1'b1;
		@(negedge clk);
		load_image = 1'b0;
		@(negedge clk);
		reset = 1'b0;
		while (!halted)
			@(negedge clk);
		repeat (20)
		begin
			@(negedge clk);
			check_value($sformatf("%s halted", name), 16'd1, {15'd0, halted});
		end
		for (int i = 0; i < `MEM_DEPTH; i++)
			check_value($sformatf("%s mem[%0d]", name, i), model_mem[i], mem[i]);
		check_value($sformatf("%s nvz", name), {13'd0, model_nvz}, {13'd0, n, v, z});
	endtask

	task automatic immediate_moves();
		int vals [7] = '{0, 127, -128, -1, 1, 0, 0};
		vals[5] = int'($urandom_range(255));
		vals[6] = int'($urandom_range(255));
		fresh_image();
		append_word(mov_imm_word(7, DATA_BASE));
		for (int i = 0; i < 7; i++)
			append_word(mov_imm_word(i, vals[i]));
		for (int i = 0; i < 8; i++)
			append_word(ldr_str_word(OPC_STR, i, 7, i));
		run_program("mov_imm");
	endtask

	task automatic register_moves();
		fresh_image();
		image[DATA_BASE] = image[DATA_BASE] | 16'h8000; // one negative source for ASR
		image[DATA_BASE + 1] = image[DATA_BASE + 1] & 16'h7fff;
		append_word(mov_imm_word(7, DATA_BASE));
		append_word(ldr_str_word(OPC_LDR, 0, 7, 0));
		append_word(ldr_str_word(OPC_LDR, 1, 7, 1));
		for (int s = 0; s < 4; s++)
		begin
			append_word(mov_reg_word(2, 0, s));
			append_word(ldr_str_word(OPC_STR, 2, 7, 8 + s));
			append_word(mov_reg_word(3, 1, s));
			append_word(ldr_str_word(OPC_STR, 3, 7, 12 + s));
		end
		run_program("mov_reg");
	endtask

	task automatic alu_results();
		alu_op_t ops [3] = '{ALU_ADD, ALU_AND, ALU_MVN};
		fresh_image();
		append_word(mov_imm_word(7, DATA_BASE));
		for (int i = 0; i < 6; i++)
			append_word(ldr_str_word(OPC_LDR, i, 7, i));
		for (int k = 0; k < 12; k++)
		begin
			append_word(alu_word(ops[k / 4], k % 6, 6, (k + 1) % 6, k % 4));
			append_word(ldr_str_word(OPC_STR, 6, 7, k - 16)); // below the base
		end
		run_program("alu");
	endtask

	// CMP, then an ADD that must not touch the flags
	task automatic compare_flags(input string name, input logic [`WORD_W-1:0] a,
		input logic [`WORD_W-1:0] b);
		fresh_image();
		image[DATA_BASE] = a;
		image[DATA_BASE + 1] = b;
		append_word(mov_imm_word(7, DATA_BASE));
		append_word(ldr_str_word(OPC_LDR, 0, 7, 0));
		append_word(ldr_str_word(OPC_LDR, 1, 7, 1));
		append_word(alu_word(ALU_CMP, 0, 0, 1, 0));
		append_word(alu_word(ALU_ADD, 0, 2, 1, 0));
		append_word(ldr_str_word(OPC_STR, 2, 7, 2));
		run_program(name);
	endtask

	task automatic loads_and_stores();
		fresh_image();
		append_word(mov_imm_word(7, DATA_BASE));
		append_word(mov_imm_word(6, 120));
		append_word(ldr_str_word(OPC_LDR, 0, 7, -16));
		append_word(ldr_str_word(OPC_LDR, 1, 7, -1));
		append_word(ldr_str_word(OPC_LDR, 2, 7, 15));
		append_word(ldr_str_word(OPC_LDR, 3, 7, 5));
		append_word(ldr_str_word(OPC_LDR, 4, 6, -10));
		for (int i = 0; i < 5; i++)
			append_word(ldr_str_word(OPC_STR, i, 6, i));
		run_program("ldr_str");
	endtask

	initial
	begin
		reset = 1'b1;
		load_image = 1'b0;
		void'($urandom(22157));
		rnd = 16'($urandom());
		immediate_moves();
		register_moves();
		alu_results();
		compare_flags("cmp_equal", rnd, rnd);
		compare_flags("cmp_overflow_pos", 16'h7fff, 16'hffff);
		compare_flags("cmp_overflow_neg", 16'h8000, 16'h0001);
		compare_flags("cmp_negative", 16'h0005, 16'h03e8);
		loads_and_stores();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+common
+incdir+testbench
common/isa_pkg.sv
common/ctrl_pkg.sv
datapath/alu.sv
datapath/datapath.sv
hdl/instr_decode.sv
controller/cpu_fsm.sv
hdl/cpu.sv
testbench/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the CPU testbench with Verilator and run it
# the exit status of the simulation binary is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f project.f --top-module tb_cpu -Mdir obj_dir

./obj_dir/Vtb_cpu
